/* design/asi_r_pkg.sv */
// Shared definitions for the AXI4 read-channel slave front end
// Bus widths, buffer depths and memory wait constant
// Burst phase, burst type and response encodings
// Packed request, beat and memory port structs
package asi_r_pkg;

    // --------------------------------------------------
    // Bus field widths
    // --------------------------------------------------
    localparam int ID_W         = 4;
    localparam int ADDR_W       = 16;
    localparam int DATA_W       = 32;
    localparam int LEN_W        = 8;
    localparam int SIZE_W       = 3;
    // 4 bytes on the data bus
    localparam int BUS_BYTES_LG = 2;

    // --------------------------------------------------
    // Buffers and memory timing
    // --------------------------------------------------
    localparam int AR_DEPTH     = 4;
    localparam int R_DEPTH      = 16;
    // Occupancy width of the R buffer, holds 0 to R_DEPTH
    localparam int R_CNT_W      = $clog2(R_DEPTH) + 1;
    // Cycles from read enable to read data
    localparam int RD_LATENCY   = 1;
    // Bit 12 flips when a burst walks into the next 4 KB page
    localparam int BOUNDARY_BIT = 12;

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------
    // First beat, remaining beats, or the idle cycle after reset
    typedef enum logic [1:0] {
        BP_FIRST = 2'b00,
        BP_BURST = 2'b01,
        BP_IDLE  = 2'b10
    } burst_phase_e;

    // AXI4 ARBURST codes
    typedef enum logic [1:0] {
        BT_FIXED    = 2'b00,
        BT_INCR     = 2'b01,
        BT_WRAP     = 2'b10,
        BT_RESERVED = 2'b11
    } burst_type_e;

    // Only the two responses this slave can give
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    // One read request as taken from the AR channel
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        burst_type_e       burst;
    } ar_req_t;

    // One beat on the R channel
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_e             resp;
        logic              last;
    } r_beat_t;

    // Read request to memory, no handshake
    typedef struct packed {
        logic              re;
        logic [ADDR_W-1:0] addr;
    } mem_req_t;

endpackage

/* design/sync_fifo.sv */
// Single-clock first-word-fall-through FIFO
// Head entry always visible on dout, with full, empty and occupancy count
module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  logic [WIDTH-1:0]       din,
    input  logic                   pop,
    output logic [WIDTH-1:0]       dout,
    output logic                   full,
    output logic                   empty,
    output logic [$clog2(DEPTH):0] count
);

    // Storage, no reset on the payload
    logic [WIDTH-1:0]         mem_q [DEPTH];
    logic [$clog2(DEPTH)-1:0] wr_ptr;
    logic [$clog2(DEPTH)-1:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    // Push into a full FIFO or pop from an empty one is dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == DEPTH);
    assign empty = (count == '0);

    // Fall-through read port
    assign dout = mem_q[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                // Wrap explicitly so DEPTH need not be a power of two
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves count unchanged
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Write port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr] <= din;
        end
    end

endmodule

/* design/burst_addr_gen.sv */
// Burst expansion into one memory read per beat
// Phase FSM, beat counter and request latch
// FIXED and INCR beat addresses with 4 KB hold, size-error response
module burst_addr_gen
    import asi_r_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  ar_req_t         head,
    input  logic            head_valid,
    output logic            pop,
    input  logic            issue_ok,
    output mem_req_t        mem,
    output logic [ID_W-1:0] beat_id,
    output resp_e           beat_resp,
    output logic            beat_last
);

    burst_phase_e      state;
    burst_phase_e      state_nxt;
    // Request latched when its first beat goes out
    ar_req_t           req_q;
    // Request currently being expanded
    ar_req_t           cur;
    logic [LEN_W-1:0]  beat_cnt;
    logic [ADDR_W-1:0] burst_addr;
    logic [ADDR_W-1:0] aligned_addr;
    logic [ADDR_W-1:0] addr_inc;
    logic [ADDR_W-1:0] addr_prev;
    logic [ADDR_W-1:0] addr_step;
    logic [ADDR_W-1:0] addr_nxt;
    logic              first_go;
    logic              burst_go;
    logic              issue;
    logic              last;

    // --------------------------------------------------
    // Beat issue control
    // --------------------------------------------------
    // Head of the AR buffer outside BP_BURST, latched copy inside it
    assign cur = (state == BP_BURST) ? req_q : head;

    // First beat needs a request waiting and R buffer credit
    assign first_go = (state == BP_FIRST) && head_valid && issue_ok;
    assign burst_go = (state == BP_BURST) && issue_ok;
    assign issue    = first_go || burst_go;

    // Single-beat request ends on its first beat
    assign last = (state == BP_BURST) ? (beat_cnt == req_q.len) : (head.len == '0);

    // --------------------------------------------------
    // Address arithmetic
    // --------------------------------------------------
    // Align start down to the transfer size
    assign aligned_addr = cur.addr & ({ADDR_W{1'b1}} << cur.size);
    // FIXED never moves, WRAP and reserved step like INCR
    assign addr_inc = (cur.burst == BT_FIXED) ? '0 : (ADDR_W'(1) << cur.size);

    always_comb begin
        if (state == BP_BURST) begin
            addr_prev = burst_addr;
            addr_step = burst_addr + addr_inc;
        end else begin
            // Beat 1 steps from the aligned start, FIXED repeats the start itself
            addr_prev = cur.addr;
            addr_step = (cur.burst == BT_FIXED) ? cur.addr : aligned_addr + addr_inc;
        end
        // Hold on a 4 KB crossing, so the address sticks for the rest of the burst
        if (addr_step[BOUNDARY_BIT] != cur.addr[BOUNDARY_BIT]) begin
            addr_nxt = addr_prev;
        end else begin
            addr_nxt = addr_step;
        end
    end

    // --------------------------------------------------
    // Phase FSM
    // --------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            BP_IDLE: begin
                state_nxt = BP_FIRST;
            end
            BP_FIRST: begin
                if (first_go && !last) begin
                    state_nxt = BP_BURST;
                end
            end
            BP_BURST: begin
                // Straight back to BP_FIRST, next burst can start next cycle
                if (burst_go && last) begin
                    state_nxt = BP_FIRST;
                end
            end
            default: begin
                state_nxt = BP_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BP_IDLE;
            beat_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Beat 0 is the first beat, so the counter restarts at 1
            if (first_go) begin
                beat_cnt <= LEN_W'(1);
            end else if (burst_go) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // Request copy and running beat address
    always_ff @(posedge clk) begin
        if (first_go) begin
            req_q <= head;
        end
        if (issue) begin
            burst_addr <= addr_nxt;
        end
    end

    // --------------------------------------------------
    // Outputs
    // --------------------------------------------------
    // Pop the AR buffer as the first beat issues
    assign pop = first_go;

    // First beat reads the request's own, possibly unaligned, address
    assign mem = '{
        re:   issue,
        addr: (state == BP_BURST) ? burst_addr : head.addr
    };

    assign beat_id   = cur.id;
    // Transfers wider than the data bus are not supported
    assign beat_resp = (cur.size > SIZE_W'(BUS_BYTES_LG)) ? RESP_SLVERR : RESP_OKAY;
    assign beat_last = last;

endmodule

/* design/rd_return_pipe.sv */
// Memory wait alignment of beat sideband with read data
// In-flight read count and R buffer credit for issue_ok
module rd_return_pipe
    import asi_r_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               mem_re,
    input  logic [ID_W-1:0]    beat_id,
    input  resp_e              beat_resp,
    input  logic               beat_last,
    input  logic [DATA_W-1:0]  mem_rdata,
    input  logic [R_CNT_W-1:0] r_count,
    output logic               issue_ok,
    output logic               push,
    output r_beat_t            beat
);

    // One stage per memory wait cycle
    logic [RD_LATENCY-1:0] re_pipe;
    logic [ID_W-1:0]       id_pipe   [RD_LATENCY];
    resp_e                 resp_pipe [RD_LATENCY];
    logic                  last_pipe [RD_LATENCY];
    logic [R_CNT_W-1:0]    in_flight;
    // Extra bit so the sum cannot wrap
    logic [R_CNT_W:0]      credit_used;

    // --------------------------------------------------
    // Delay line
    // --------------------------------------------------
    // Read enables are control, reset them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            re_pipe <= '0;
        end else begin
            re_pipe[0] <= mem_re;
            for (int i = 1; i < RD_LATENCY; i++) begin
                re_pipe[i] <= re_pipe[i-1];
            end
        end
    end

    // Sideband only matters where re_pipe is set
    always_ff @(posedge clk) begin
        id_pipe[0]   <= beat_id;
        resp_pipe[0] <= beat_resp;
        last_pipe[0] <= beat_last;
        for (int i = 1; i < RD_LATENCY; i++) begin
            id_pipe[i]   <= id_pipe[i-1];
            resp_pipe[i] <= resp_pipe[i-1];
            last_pipe[i] <= last_pipe[i-1];
        end
    end

    // Sideband meets its data at the end of the wait
    assign push = re_pipe[RD_LATENCY-1];
    assign beat = '{
        id:   id_pipe[RD_LATENCY-1],
        data: mem_rdata,
        resp: resp_pipe[RD_LATENCY-1],
        last: last_pipe[RD_LATENCY-1]
    };

    // --------------------------------------------------
    // Credit
    // --------------------------------------------------
    // Reads issued and not yet written into the R buffer
    always_comb begin
        in_flight = '0;
        for (int i = 0; i < RD_LATENCY; i++) begin
            in_flight = in_flight + re_pipe[i];
        end
    end

    assign credit_used = {1'b0, r_count} + in_flight;
    // Stop reading once every R buffer slot is spoken for
    assign issue_ok    = (credit_used < R_DEPTH);

endmodule

/* design/asi_r.sv */
// AXI4 read-channel slave front end, top level
// AR buffer, burst address generator, memory return pipe and R buffer
module asi_r
    import asi_r_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    // AR channel
    input  ar_req_t           ar,
    input  logic              arvalid,
    output logic              arready,
    // R channel
    output r_beat_t           r,
    output logic              rvalid,
    input  logic              rready,
    // Memory port
    output mem_req_t          mem,
    input  logic [DATA_W-1:0] mem_rdata
);

    // AR buffer side
    ar_req_t            ar_head;
    logic               ar_full;
    logic               ar_empty;
    logic               ar_pop;
    // Beat sideband, valid with mem.re
    logic [ID_W-1:0]    beat_id;
    resp_e              beat_resp;
    logic               beat_last;
    logic               issue_ok;
    // R buffer side
    logic               r_push;
    r_beat_t            r_beat_in;
    logic               r_empty;
    logic [R_CNT_W-1:0] r_count;

    assign arready = !ar_full;
    assign rvalid  = !r_empty;

    // --------------------------------------------------
    // AR buffer
    // --------------------------------------------------
    // Push is gated by full inside the FIFO, so arvalid alone is the push
    sync_fifo #(
        .WIDTH ($bits(ar_req_t)),
        .DEPTH (AR_DEPTH)
    ) u_ar_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (arvalid),
        .din   (ar),
        .pop   (ar_pop),
        .dout  (ar_head),
        .full  (ar_full),
        .empty (ar_empty),
        .count ()
    );

    // --------------------------------------------------
    // Burst expansion
    // --------------------------------------------------
    burst_addr_gen u_burst_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .head       (ar_head),
        .head_valid (!ar_empty),
        .pop        (ar_pop),
        .issue_ok   (issue_ok),
        .mem        (mem),
        .beat_id    (beat_id),
        .beat_resp  (beat_resp),
        .beat_last  (beat_last)
    );

    // --------------------------------------------------
    // Memory return and credit
    // --------------------------------------------------
    rd_return_pipe u_rd_return_pipe (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_re    (mem.re),
        .beat_id   (beat_id),
        .beat_resp (beat_resp),
        .beat_last (beat_last),
        .mem_rdata (mem_rdata),
        .r_count   (r_count),
        .issue_ok  (issue_ok),
        .push      (r_push),
        .beat      (r_beat_in)
    );

    // --------------------------------------------------
    // R buffer
    // --------------------------------------------------
    // Credit keeps it from overflowing, full is not needed here
    sync_fifo #(
        .WIDTH ($bits(r_beat_t)),
        .DEPTH (R_DEPTH)
    ) u_r_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (r_push),
        .din   (r_beat_in),
        .pop   (rready),
        .dout  (r),
        .full  (),
        .empty (r_empty),
        .count (r_count)
    );

endmodule

/* test/asi_r_tb.sv */
// Testbench for the AXI4 read-channel slave front end
// Clock, reset, one-cycle memory model, stimulus table and expected-beat queue
// Typed compare tasks, cycle timeout and closing summary
module asi_r_tb
    import asi_r_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    // One table row: request, rready stall enable, beats the request must return
    typedef struct packed {
        ar_req_t    req;
        logic       stall;
        logic [8:0] beats;
    } stim_t;

    localparam int NUM_STIM = 11;

    logic              clk;
    logic              rst_n;
    ar_req_t           ar;
    logic              arvalid;
    logic              arready;
    r_beat_t           r;
    logic              rvalid;
    logic              rready;
    mem_req_t          mem;
    logic [DATA_W-1:0] mem_rdata;

    stim_t             stim_table [NUM_STIM];
    r_beat_t           exp_q [$];
    int                exp_cnt_q [$];
    int                seed;
    logic [31:0]       rnd;
    logic              stall_en;
    logic              stall_now;
    // Memory request seen mid-cycle
    logic              mem_re_s;
    logic [ADDR_W-1:0] mem_addr_s;
    int                mismatch_cnt;
    int                other_cnt;
    int                beats_seen;
    int                beats_rx;
    int                cycle_cnt;
    int                cycle_limit;
    int                total_beats;

    asi_r u_asi_r (
        .clk       (clk),
        .rst_n     (rst_n),
        .ar        (ar),
        .arvalid   (arvalid),
        .arready   (arready),
        .r         (r),
        .rvalid    (rvalid),
        .rready    (rready),
        .mem       (mem),
        .mem_rdata (mem_rdata)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    task automatic compare_resp(input resp_e got, input resp_e exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s resp got %s expected %s",
                     $time, what, got.name(), exp.name());
            mismatch_cnt++;
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
            mismatch_cnt++;
        end
    endtask

    // Each field of a beat checked on its own
    task automatic compare_beat(input r_beat_t got, input r_beat_t exp, input int idx);
        if (got.id !== exp.id) begin
            $display("MISMATCH at %0t: beat %0d id got %0h expected %0h",
                     $time, idx, got.id, exp.id);
            mismatch_cnt++;
        end
        if (got.data !== exp.data) begin
            $display("MISMATCH at %0t: beat %0d data got %h expected %h",
                     $time, idx, got.data, exp.data);
            mismatch_cnt++;
        end
        compare_resp(got.resp, exp.resp, $sformatf("beat %0d", idx));
        compare_bit(got.last, exp.last, $sformatf("beat %0d last", idx));
    endtask

    // --------------------------------------------------
    // Stimulus table and expected beats
    // --------------------------------------------------
    function automatic stim_t make_stim(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                                        input logic [LEN_W-1:0] len, input logic [SIZE_W-1:0] size,
                                        input burst_type_e burst, input logic stall);
        stim_t s;
        s.req.id    = id;
        s.req.addr  = addr;
        s.req.len   = len;
        s.req.size  = size;
        s.req.burst = burst;
        s.stall     = stall;
        s.beats     = 9'(len) + 9'd1;
        return s;
    endfunction

    task automatic load_table();
        stim_table[0]  = make_stim(4'h1, 16'h0102, 8'd0, 3'd2, BT_INCR, 1'b0);
        stim_table[1]  = make_stim(4'h2, 16'h0206, 8'd7, 3'd2, BT_INCR, 1'b0);
        stim_table[2]  = make_stim(4'h3, 16'h0312, 8'd3, 3'd2, BT_FIXED, 1'b0);
        // Crosses into the next 4 KB page on beat 2
        stim_table[3]  = make_stim(4'h4, 16'h0FF8, 8'd5, 3'd2, BT_INCR, 1'b0);
        // Wider than the 32-bit bus
        stim_table[4]  = make_stim(4'h5, 16'h0400, 8'd3, 3'd3, BT_INCR, 1'b0);
        // Back-to-back with random rready from here on
        stim_table[5]  = make_stim(4'h6, 16'h0500, 8'd3, 3'd2, BT_INCR, 1'b1);
        stim_table[6]  = make_stim(4'h7, 16'h0601, 8'd19, 3'd1, BT_INCR, 1'b1);
        stim_table[7]  = make_stim(4'h8, 16'h0700, 8'd0, 3'd0, BT_INCR, 1'b1);
        stim_table[8]  = make_stim(4'h9, 16'h0808, 8'd7, 3'd2, BT_WRAP, 1'b1);
        stim_table[9]  = make_stim(4'hA, 16'h1F00, 8'd2, 3'd3, BT_FIXED, 1'b1);
        stim_table[10] = make_stim(4'hB, 16'h0A40, 8'd15, 3'd2, BT_RESERVED, 1'b1);
    endtask

    // Beat addresses from the AXI rules, WRAP and reserved step like INCR
    function automatic void expand_burst(input ar_req_t req);
        logic [ADDR_W-1:0] start_al;
        logic [ADDR_W-1:0] cur_addr;
        logic [ADDR_W-1:0] nxt_addr;
        resp_e             resp;
        r_beat_t           beat;
        // Bytes per beat beyond the bus width is an error
        resp     = ((1 << req.size) > DATA_W / 8) ? RESP_SLVERR : RESP_OKAY;
        start_al = (req.addr >> req.size) << req.size;
        cur_addr = req.addr;
        for (int b = 0; b <= int'(req.len); b++) begin
            if (b > 0) begin
                if (req.burst == BT_FIXED) begin
                    nxt_addr = req.addr;
                end else begin
                    nxt_addr = start_al + (ADDR_W'(b) << req.size);
                end
                // Stay on the last address inside the start page
                if (nxt_addr[BOUNDARY_BIT] != req.addr[BOUNDARY_BIT]) begin
                    nxt_addr = cur_addr;
                end
                cur_addr = nxt_addr;
            end
            beat.id   = req.id;
            beat.data = {~cur_addr, cur_addr};
            beat.resp = resp;
            beat.last = (b == int'(req.len));
            exp_q.push_back(beat);
        end
        exp_cnt_q.push_back(int'(req.len) + 1);
    endfunction

    task automatic report_counts();
        $display("Summary: %0d beats received, %0d mismatches, %0d other errors",
                 beats_rx, mismatch_cnt, other_cnt);
    endtask

    // --------------------------------------------------
    // Memory model and R channel
    // --------------------------------------------------
    always @(negedge clk) begin
        mem_re_s   <= mem.re;
        mem_addr_s <= mem.addr;
    end

    // Data one cycle after the read, inverted address over address
    always @(posedge clk) begin
        #2;
        mem_rdata = mem_re_s ? {~mem_addr_s, mem_addr_s} : '0;
    end

    always @(posedge clk) begin
        stall_now = stall_en;
        #2;
        if (!rst_n) begin
            rready = 1'b0;
        end else if (stall_now) begin
            rnd    = $random(seed);
            rready = rnd[0];
        end else begin
            rready = 1'b1;
        end
    end

    // Beat transfers on the coming edge
    always @(negedge clk) begin : r_monitor
        r_beat_t exp;
        if (rst_n && rvalid && rready) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected beat at %0t with id %0h, nothing was outstanding",
                         $time, r.id);
                other_cnt++;
            end else begin
                exp = exp_q.pop_front();
                compare_beat(r, exp, beats_rx);
                beats_seen++;
                // Burst length counted up to the last flag the DUT sends
                if (r.last) begin
                    if (exp_cnt_q.size() == 0) begin
                        $display("Extra last flag at %0t with id %0h, no burst was open",
                                 $time, r.id);
                        other_cnt++;
                    end else begin
                        compare_count(beats_seen, exp_cnt_q.pop_front(), "burst beat count");
                    end
                    beats_seen = 0;
                end
            end
            beats_rx++;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, %0d beats still outstanding",
                     cycle_cnt, exp_q.size());
            other_cnt++;
            report_counts();
            $display("Verification failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        ar           = '0;
        arvalid      = 1'b0;
        rready       = 1'b0;
        mem_rdata    = '0;
        stall_en     = 1'b0;
        seed         = 32'h5247_bd69;
        mismatch_cnt = 0;
        other_cnt    = 0;
        beats_seen   = 0;
        beats_rx     = 0;
        cycle_cnt    = 0;
        total_beats  = 0;
        load_table();
        for (int i = 0; i < NUM_STIM; i++) begin
            total_beats += int'(stim_table[i].beats);
        end
        cycle_limit = 40 * total_beats + 200;

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        compare_bit(arready, 1'b1, "arready after reset");
        compare_bit(rvalid, 1'b0, "rvalid after reset");
        compare_bit(mem.re, 1'b0, "mem.re after reset");

        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_STIM; i++) begin
            expand_burst(stim_table[i].req);
            ar       = stim_table[i].req;
            arvalid  = 1'b1;
            stall_en = stim_table[i].stall;
            // Hold the request until arready lets it through
            do begin
                @(negedge clk);
            end while (!arready);
            @(posedge clk);
            #2;
        end
        arvalid = 1'b0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // Idle tail to catch duplicated beats
        repeat (20) @(posedge clk);
        @(negedge clk);
        compare_bit(rvalid, 1'b0, "rvalid when idle");
        compare_bit(mem.re, 1'b0, "mem.re when idle");
        compare_count(exp_cnt_q.size(), 0, "bursts left unfinished");

        report_counts();
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/asi_r_pkg.sv
design/sync_fifo.sv
design/burst_addr_gen.sv
design/rd_return_pipe.sv
design/asi_r.sv
test/asi_r_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the asi_r testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    -f vlog.f \
    --top-module asi_r_tb \
    -o asi_r_sim

./obj_dir/asi_r_sim > sim.log 2>&1
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
